// ==== design/cache_params.svh ====
// ----------------------------------------------------------
// Data cache parameters
// Block geometry, address split and bus response codes
// ----------------------------------------------------------
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Block geometry, one block of CACHE_WORDS words
`define CACHE_WORDS 128
`define WORD_W      32
`define BYTES_W     4

// Address split as tag, word index and byte offset
`define ADDR_W      32
`define OFFSET_W    2
`define INDEX_W     7
// Tag covers everything above the word index
`define TAG_LSB     9

// Write response code for a good transfer
`define RESP_OKAY   2'd0

`endif

// ==== design/cache_types_pkg.sv ====
// ----------------------------------------------------------
// CPU side types of the data cache
// Request struct, word and address fields, FSM states
// ----------------------------------------------------------
`default_nettype none

`include "cache_params.svh"

package cache_types_pkg;

    typedef logic [`WORD_W-1:0]           cpu_word_t;
    typedef logic [`BYTES_W-1:0]          byte_en_t;
    // Upper address bits, shared by all words of the block
    typedef logic [`ADDR_W-`TAG_LSB-1:0]  block_tag_t;
    typedef logic [`INDEX_W-1:0]          word_index_t;

    // One CPU request, held stable while stall is high
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        cpu_word_t          wdata;
        logic               read;
        logic               write;
        byte_en_t           byte_en;
    } cpu_req_t;

    // Controller states, write-back always runs before fill
    typedef enum logic [2:0] {
        IDLE, WB_ADDR, WB_DATA, WB_RESP, FILL_ADDR, FILL_DATA
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/axi_burst_pkg.sv ====
// ----------------------------------------------------------
// Memory side channel types
// Reduced AXI burst channels, ready travels separately
// ----------------------------------------------------------
`default_nettype none

`include "cache_params.svh"

package axi_burst_pkg;

    typedef logic [`ADDR_W-1:0] axi_addr_t;
    typedef logic [1:0]         axi_resp_t;

    // ----------------------------------------------------------
    // Address channels, same layout for AW and AR
    // ----------------------------------------------------------
    typedef struct packed {
        axi_addr_t addr;
        logic      valid;
    } axi_addr_ch_t;

    // ----------------------------------------------------------
    // Data and response channels
    // ----------------------------------------------------------
    // Write data, strobes are always full
    typedef struct packed {
        logic [`WORD_W-1:0] data;
        logic               last;
        logic               valid;
    } axi_w_ch_t;

    typedef struct packed {
        axi_resp_t resp;
        logic      valid;
    } axi_b_ch_t;

    // Read data, resp dropped since the slave always answers OKAY
    typedef struct packed {
        logic [`WORD_W-1:0] data;
        logic               last;
        logic               valid;
    } axi_r_ch_t;

endpackage

`default_nettype wire

// ==== design/cache_block_store.sv ====
// ----------------------------------------------------------
// Cache block store
// Data array with tag, valid and dirty flags of the block
// Hit detection and byte merged CPU writes
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_block_store (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  cache_types_pkg::cpu_req_t     req,
    input  logic                          accept,
    input  logic                          fill_we,
    input  logic                          fill_done,
    input  logic                          flush_done,
    input  cache_types_pkg::word_index_t  word_ptr,
    input  cache_types_pkg::cpu_word_t    fill_word,
    output logic                          hit,
    output logic                          dirty,
    output cache_types_pkg::block_tag_t   block_tag,
    output cache_types_pkg::cpu_word_t    read_data,
    output cache_types_pkg::cpu_word_t    ptr_word
);
    import cache_types_pkg::*;

    // Block data words qualified only by the valid flag
    cpu_word_t   data_q [`CACHE_WORDS];
    logic        valid;
    block_tag_t  req_tag;
    word_index_t req_index;
    cpu_word_t   be_mask;
    cpu_word_t   merged;
    logic        hit_write;

    // Split of the request address
    assign req_tag   = req.addr[`ADDR_W-1:`TAG_LSB];
    assign req_index = req.addr[`TAG_LSB-1:`OFFSET_W];

    assign hit = valid & (req_tag == block_tag);

    // Writes land only when the controller sits idle
    // A write with no byte enabled leaves the block clean
    assign hit_write = accept & hit & req.write & (|req.byte_en);

    // Byte enables widened to a bit mask
    always_comb begin
        for (int i = 0; i < `BYTES_W; i++) begin
            be_mask[8*i +: 8] = {8{req.byte_en[i]}};
        end
    end

    assign merged = (data_q[req_index] & ~be_mask) | (req.wdata & be_mask);

    // Combinational read ports
    assign read_data = data_q[req_index];
    // Write-back source at the burst pointer
    assign ptr_word  = data_q[word_ptr];

    // ----------------------------------------------------------
    // Data array
    // ----------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (fill_we) begin
            data_q[word_ptr] <= fill_word;
        end else if (hit_write) begin
            data_q[req_index] <= merged;
        end
    end

    // ----------------------------------------------------------
    // Tag and flags
    // ----------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            dirty     <= 1'b0;
            block_tag <= '0;
        end else if (fill_done) begin
            // Last fill beat hands the block to the request
            block_tag <= req_tag;
            valid     <= 1'b1;
            dirty     <= 1'b0;
        end else if (flush_done) begin
            dirty     <= 1'b0;
        end else if (hit_write) begin
            dirty     <= 1'b1;
        end
    end

    // Fill beats arrive outside IDLE and CPU writes only inside it
    assert property (@(posedge aclk) disable iff (!rst_n)
        !(fill_we && hit_write));

endmodule

`default_nettype wire

// ==== design/cache_controller.sv ====
// ----------------------------------------------------------
// Cache controller
// Miss, write-back and flush FSM with one outstanding burst
// Drives the memory channels and the block word pointer
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_controller (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  cache_types_pkg::cpu_req_t     req,
    input  logic                          hit,
    input  logic                          dirty,
    input  cache_types_pkg::block_tag_t   block_tag,
    input  cache_types_pkg::cpu_word_t    ptr_word,
    input  logic                          flush_order,
    output logic                          accept,
    output logic                          stall,
    output logic                          fill_we,
    output logic                          fill_done,
    output logic                          flush_done,
    output logic                          bus_error,
    output cache_types_pkg::word_index_t  word_ptr,
    output cache_types_pkg::cpu_word_t    fill_word,
    output axi_burst_pkg::axi_addr_ch_t   aw,
    output axi_burst_pkg::axi_addr_ch_t   ar,
    input  logic                          awready,
    input  logic                          arready,
    output axi_burst_pkg::axi_w_ch_t      w,
    input  logic                          wready,
    input  axi_burst_pkg::axi_b_ch_t      b,
    output logic                          bready,
    input  axi_burst_pkg::axi_r_ch_t      r,
    output logic                          rready
);
    import cache_types_pkg::*;
    import axi_burst_pkg::*;

    ctrl_state_t state, next_state;
    // Set while the write-back comes from a CSR flush
    logic        flushing, next_flushing;
    word_index_t next_word_ptr;
    logic        miss;
    logic        last_word;
    logic        b_err;

    assign miss      = (req.read | req.write) & ~hit;
    assign last_word = (word_ptr == word_index_t'(`CACHE_WORDS - 1));
    assign fill_word = r.data;

    // Busy outside IDLE, or a request that cannot be served now
    assign stall = (state != IDLE) | miss | (flush_order & (req.read | req.write));

    // Any response other than OKAY is flagged, the burst still ends
    assign b_err = b.valid & bready & (b.resp != `RESP_OKAY);

    // ----------------------------------------------------------
    // State registers
    // ----------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state     <= IDLE;
            flushing  <= 1'b0;
            word_ptr  <= '0;
            bus_error <= 1'b0;
        end else begin
            state     <= next_state;
            flushing  <= next_flushing;
            word_ptr  <= next_word_ptr;
            bus_error <= b_err;
        end
    end

    // ----------------------------------------------------------
    // Next state and channel outputs
    // ----------------------------------------------------------
    always_comb begin
        next_state    = state;
        next_flushing = flushing;
        next_word_ptr = word_ptr;
        accept        = 1'b0;
        fill_we       = 1'b0;
        fill_done     = 1'b0;
        flush_done    = 1'b0;
        bready        = 1'b0;
        rready        = 1'b0;
        // Addresses are block aligned, write-back uses the stored tag
        aw.addr  = {block_tag, {`TAG_LSB{1'b0}}};
        aw.valid = 1'b0;
        ar.addr  = {req.addr[`ADDR_W-1:`TAG_LSB], {`TAG_LSB{1'b0}}};
        ar.valid = 1'b0;
        w.data   = ptr_word;
        w.last   = last_word;
        w.valid  = 1'b0;

        case (state)
            IDLE: begin
                next_word_ptr = '0;
                if (flush_order) begin
                    // Flush takes priority over a pending miss
                    next_flushing = 1'b1;
                    next_state    = WB_ADDR;
                end else if (miss) begin
                    next_state = dirty ? WB_ADDR : FILL_ADDR;
                end else begin
                    accept = 1'b1;
                end
            end
            WB_ADDR: begin
                aw.valid = 1'b1;
                if (awready) next_state = WB_DATA;
            end
            WB_DATA: begin
                w.valid = 1'b1;
                if (wready) begin
                    // Pointer wraps to zero after the last beat
                    next_word_ptr = word_ptr + 1'b1;
                    if (last_word) next_state = WB_RESP;
                end
            end
            WB_RESP: begin
                bready = 1'b1;
                if (b.valid) begin
                    if (flushing) begin
                        flush_done    = 1'b1;
                        next_flushing = 1'b0;
                        next_state    = IDLE;
                    end else begin
                        next_state = FILL_ADDR;
                    end
                end
            end
            FILL_ADDR: begin
                ar.valid = 1'b1;
                if (arready) next_state = FILL_DATA;
            end
            FILL_DATA: begin
                rready = 1'b1;
                if (r.valid) begin
                    fill_we       = 1'b1;
                    next_word_ptr = word_ptr + 1'b1;
                    if (r.last) begin
                        fill_done  = 1'b1;
                        next_state = IDLE;
                    end
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // Payload frozen while the slave holds off ready
    assert property (@(posedge aclk) disable iff (!rst_n)
        aw.valid && !awready |=> aw.valid && $stable(aw.addr));
    assert property (@(posedge aclk) disable iff (!rst_n)
        ar.valid && !arready |=> ar.valid && $stable(ar.addr));
    assert property (@(posedge aclk) disable iff (!rst_n)
        w.valid && !wready |=> w.valid && $stable(w.data) && $stable(w.last));

    // CPU never asks for a read and a write at once
    assert property (@(posedge aclk) disable iff (!rst_n)
        !(req.read && req.write));

endmodule

`default_nettype wire

// ==== design/data_cache_top.sv ====
// ----------------------------------------------------------
// Direct mapped write-back data cache, one block
// Block store plus burst controller on a reduced AXI master
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module data_cache_top (
    input  logic                          aclk,
    input  logic                          rst_n,
    // CPU port
    input  cache_types_pkg::cpu_req_t     cpu_req,
    output cache_types_pkg::cpu_word_t    read_data,
    output logic                          stall,
    // CSR flush order
    input  logic                          flush_order,
    // Memory burst master
    output axi_burst_pkg::axi_addr_ch_t   aw,
    output axi_burst_pkg::axi_addr_ch_t   ar,
    input  logic                          awready,
    input  logic                          arready,
    output axi_burst_pkg::axi_w_ch_t      w,
    input  logic                          wready,
    input  axi_burst_pkg::axi_b_ch_t      b,
    output logic                          bready,
    input  axi_burst_pkg::axi_r_ch_t      r,
    output logic                          rready,
    output logic                          bus_error
);
    import cache_types_pkg::*;

    // Controller to store
    logic        accept, fill_we, fill_done, flush_done;
    word_index_t word_ptr;
    cpu_word_t   fill_word;
    // Store to controller
    logic        hit, dirty;
    block_tag_t  block_tag;
    cpu_word_t   ptr_word;

    cache_block_store store_i (
        .aclk, .rst_n, .req(cpu_req), .accept, .fill_we, .fill_done,
        .flush_done, .word_ptr, .fill_word, .hit, .dirty, .block_tag,
        .read_data, .ptr_word
    );

    cache_controller ctrl_i (
        .aclk, .rst_n, .req(cpu_req), .hit, .dirty, .block_tag, .ptr_word,
        .flush_order, .accept, .stall, .fill_we, .fill_done, .flush_done,
        .bus_error, .word_ptr, .fill_word, .aw, .ar, .awready, .arready,
        .w, .wready, .b, .bready, .r, .rready
    );

endmodule

`default_nettype wire

// ==== testbench/axi_mem_model.sv ====
// ----------------------------------------------------------
// Burst memory slave for the data cache testbench
// Random ready and valid gaps, backdoor word array
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module axi_mem_model #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  axi_burst_pkg::axi_addr_ch_t   aw,
    input  axi_burst_pkg::axi_addr_ch_t   ar,
    output logic                          awready,
    output logic                          arready,
    input  axi_burst_pkg::axi_w_ch_t      w,
    output logic                          wready,
    output axi_burst_pkg::axi_b_ch_t      b,
    input  logic                          bready,
    output axi_burst_pkg::axi_r_ch_t      r,
    input  logic                          rready
);
    import axi_burst_pkg::*;

    localparam int MEM_AW = $clog2(MEM_WORDS);

    // Backdoor array, loaded and inspected by the testbench
    logic [`WORD_W-1:0] mem [MEM_WORDS];
    integer             seed = 25;
    logic               wr_active;
    logic               rd_active;
    int                 wr_idx;
    int                 rd_idx;

    // Ready or valid offered in about three cycles of four
    function automatic logic pick_ready();
        return ($random(seed) % 4) != 0;
    endfunction

    always @(posedge aclk) begin
        if (!rst_n) begin
            awready   <= 1'b0;
            arready   <= 1'b0;
            wready    <= 1'b0;
            b         <= '0;
            r         <= '0;
            wr_active <= 1'b0;
            rd_active <= 1'b0;
        end else begin
            // ----------------------------------------------------------
            // Write side, one burst at a time
            // ----------------------------------------------------------
            awready <= !wr_active && !b.valid && pick_ready();
            wready  <= wr_active && pick_ready();
            if (aw.valid && awready) begin
                wr_active <= 1'b1;
                wr_idx    <= int'(aw.addr[`OFFSET_W +: MEM_AW]);
                awready   <= 1'b0;
            end
            if (w.valid && wready) begin
                mem[wr_idx] <= w.data;
                wr_idx      <= wr_idx + 1;
                if (w.last) begin
                    // Burst done, answer with OKAY
                    wr_active <= 1'b0;
                    wready    <= 1'b0;
                    b.valid   <= 1'b1;
                    b.resp    <= `RESP_OKAY;
                end
            end
            // Response held until the master takes it
            if (b.valid && bready) begin
                b.valid <= 1'b0;
            end

            // ----------------------------------------------------------
            // Read side, beats spaced by at least one idle cycle
            // ----------------------------------------------------------
            arready <= !rd_active && pick_ready();
            if (ar.valid && arready) begin
                rd_active <= 1'b1;
                rd_idx    <= int'(ar.addr[`OFFSET_W +: MEM_AW]);
                arready   <= 1'b0;
            end
            if (r.valid && rready) begin
                r.valid <= 1'b0;
                rd_idx  <= rd_idx + 1;
                if (r.last) begin
                    rd_active <= 1'b0;
                end
            end else if (rd_active && !r.valid && pick_ready()) begin
                r.valid <= 1'b1;
                r.data  <= mem[rd_idx];
                // Bursts are block aligned, last beat ends the block
                r.last  <= (rd_idx % `CACHE_WORDS) == `CACHE_WORDS - 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_data_cache.sv ====
// ----------------------------------------------------------
// Data cache testbench
// Stimulus table against a golden word array and burst monitor
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_data_cache;
    import cache_types_pkg::*;
    import axi_burst_pkg::*;

    localparam int MEM_WORDS  = 1024;
    localparam int NUM_ROWS   = 17;
    localparam int CLK_NS     = 40;
    localparam int TIMEOUT_NS = NUM_ROWS * 4 * `CACHE_WORDS * CLK_NS;
    localparam logic [1:0] OP_READ  = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_FLUSH = 2'd2;

    // One table row with data and byte_en unused for reads and flushes
    typedef struct packed {
        logic [1:0] op;
        axi_addr_t  addr;
        cpu_word_t  data;
        byte_en_t   be;
    } row_t;

    logic         aclk = 1'b0;
    logic         rst_n;
    cpu_req_t     cpu_req;
    cpu_word_t    read_data;
    logic         stall;
    logic         flush_order;
    axi_addr_ch_t aw;
    axi_addr_ch_t ar;
    logic         awready;
    logic         arready;
    axi_w_ch_t    w;
    logic         wready;
    axi_b_ch_t    b;
    logic         bready;
    axi_r_ch_t    r;
    logic         rready;
    logic         bus_error;

    row_t         stim [NUM_ROWS];
    // CPU view of memory updated by every write
    cpu_word_t    golden [MEM_WORDS];
    integer       seed = 25;
    // Expected block state
    logic         g_valid;
    logic         g_dirty;
    block_tag_t   g_tag;
    // Burst monitor counts cleared at the start of each row
    int           aw_count;
    int           ar_count;
    int           w_beats;
    int           r_beats;
    axi_addr_t    aw_addr;
    axi_addr_t    ar_addr;
    logic         last_err;
    logic         err_seen;

    always #(CLK_NS / 2) aclk = ~aclk;

    data_cache_top dut_i (
        .aclk, .rst_n, .cpu_req, .read_data, .stall, .flush_order, .aw, .ar,
        .awready, .arready, .w, .wready, .b, .bready, .r, .rready, .bus_error
    );

    axi_mem_model #(.MEM_WORDS(MEM_WORDS)) mem_i (
        .aclk, .rst_n, .aw, .ar, .awready, .arready, .w, .wready, .b, .bready,
        .r, .rready
    );

    // ----------------------------------------------------------
    // Burst monitor
    // ----------------------------------------------------------
    always @(posedge aclk) begin
        if (aw.valid && awready) begin
            aw_count++;
            aw_addr = aw.addr;
        end
        if (ar.valid && arready) begin
            ar_count++;
            ar_addr = ar.addr;
        end
        if (w.valid && wready) begin
            w_beats++;
            // last only on the final beat of the block
            if (w.last != (w_beats == `CACHE_WORDS)) last_err = 1'b1;
        end
        if (r.valid && rready) r_beats++;
        if (bus_error) err_seen = 1'b1;
    end

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_word(input string name, input cpu_word_t act, input cpu_word_t exp);
        if (act !== exp) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, act, exp);
            report_failure();
        end
    endtask

    task automatic check_addr(input string name, input axi_addr_t act, input axi_addr_t exp);
        if (act !== exp) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, act, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, act, exp);
            report_failure();
        end
    endtask

    // Sample 1 ns after each edge until the cache is free
    task automatic wait_idle();
        while (stall) begin
            @(posedge aclk);
            #1;
        end
    endtask

    // Memory copy of a written back block against the CPU view
    task automatic check_block(input block_tag_t tag);
        int base;
        base = int'(tag) * `CACHE_WORDS;
        for (int i = 0; i < `CACHE_WORDS; i++) begin
            check_word($sformatf("mem[%0d]", base + i), mem_i.mem[base + i], golden[base + i]);
        end
    endtask

    task automatic check_bursts(input logic exp_wb, input block_tag_t wb_tag,
                                input logic exp_fill, input block_tag_t fill_tag);
        check_flag("aw handshake", aw_count != 0, exp_wb);
        check_flag("ar handshake", ar_count != 0, exp_fill);
        if (exp_wb) begin
            check_flag("single aw", aw_count == 1, 1'b1);
            check_addr("aw.addr", aw_addr, {wb_tag, {`TAG_LSB{1'b0}}});
            check_flag("w beat count", w_beats == `CACHE_WORDS, 1'b1);
            check_flag("w.last misplaced", last_err, 1'b0);
            check_block(wb_tag);
        end
        if (exp_fill) begin
            check_flag("single ar", ar_count == 1, 1'b1);
            check_addr("ar.addr", ar_addr, {fill_tag, {`TAG_LSB{1'b0}}});
            check_flag("r beat count", r_beats == `CACHE_WORDS, 1'b1);
        end
        // A pulse from the final response is still on the wire here
        check_flag("bus_error", err_seen | bus_error, 1'b0);
    endtask

    // Watchdog sized from the table length
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out before the stimulus table finished");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        row_t       row;
        block_tag_t tag;
        int         idx;
        logic       exp_miss;
        // Miss, hits, partial writes, dirty eviction, flushes, refill
        stim[0]  = '{OP_READ,  32'h0000_0104, 32'h0000_0000, 4'h0};
        stim[1]  = '{OP_READ,  32'h0000_0108, 32'h0000_0000, 4'h0};
        stim[2]  = '{OP_READ,  32'h0000_01FC, 32'h0000_0000, 4'h0};
        stim[3]  = '{OP_WRITE, 32'h0000_0108, 32'hA5A5_1234, 4'b0011};
        stim[4]  = '{OP_READ,  32'h0000_0108, 32'h0000_0000, 4'h0};
        stim[5]  = '{OP_WRITE, 32'h0000_0110, 32'hDEAD_BEEF, 4'b1100};
        stim[6]  = '{OP_WRITE, 32'h0000_0114, 32'h0BAD_F00D, 4'b1111};
        stim[7]  = '{OP_READ,  32'h0000_0110, 32'h0000_0000, 4'h0};
        stim[8]  = '{OP_READ,  32'h0000_0604, 32'h0000_0000, 4'h0};
        stim[9]  = '{OP_READ,  32'h0000_0600, 32'h0000_0000, 4'h0};
        stim[10] = '{OP_WRITE, 32'h0000_07F0, 32'h1357_9BDF, 4'b0100};
        stim[11] = '{OP_FLUSH, 32'h0000_0000, 32'h0000_0000, 4'h0};
        stim[12] = '{OP_READ,  32'h0000_0A00, 32'h0000_0000, 4'h0};
        stim[13] = '{OP_WRITE, 32'h0000_0A04, 32'hCAFE_0001, 4'b1001};
        stim[14] = '{OP_FLUSH, 32'h0000_0000, 32'h0000_0000, 4'h0};
        stim[15] = '{OP_READ,  32'h0000_0004, 32'h0000_0000, 4'h0};
        stim[16] = '{OP_READ,  32'h0000_0108, 32'h0000_0000, 4'h0};

        rst_n       = 1'b0;
        cpu_req     = '0;
        flush_order = 1'b0;
        g_valid     = 1'b0;
        g_dirty     = 1'b0;
        g_tag       = '0;
        // Same values into the golden array and the model memory
        for (int i = 0; i < MEM_WORDS; i++) begin
            golden[i]    = $random(seed);
            mem_i.mem[i] = golden[i];
        end

        repeat (8) @(posedge aclk);
        #5 rst_n = 1'b1;
        #1;
        check_flag("stall", stall, 1'b0);
        check_flag("aw.valid", aw.valid, 1'b0);
        check_flag("ar.valid", ar.valid, 1'b0);
        check_flag("w.valid", w.valid, 1'b0);
        check_flag("bready", bready, 1'b0);
        check_flag("rready", rready, 1'b0);
        check_flag("bus_error", bus_error, 1'b0);
        @(posedge aclk);
        #5;

        // ----------------------------------------------------------
        // Table loop with each row starting 5 ns after an edge
        // ----------------------------------------------------------
        for (int n = 0; n < NUM_ROWS; n++) begin
            row      = stim[n];
            tag      = row.addr[`ADDR_W-1:`TAG_LSB];
            idx      = int'(row.addr[`ADDR_W-1:`OFFSET_W]);
            aw_count = 0;
            ar_count = 0;
            w_beats  = 0;
            r_beats  = 0;
            last_err = 1'b0;
            err_seen = 1'b0;
            if (row.op == OP_FLUSH) begin
                cpu_req     = '0;
                flush_order = 1'b1;
                @(posedge aclk);
                #5 flush_order = 1'b0;
                #1;
                check_flag("stall", stall, 1'b1);
                wait_idle();
                check_bursts(1'b1, g_tag, 1'b0, '0);
                g_dirty = 1'b0;
                #4;
            end else begin
                exp_miss        = !(g_valid && g_tag == tag);
                cpu_req.addr    = row.addr;
                cpu_req.wdata   = row.data;
                cpu_req.read    = (row.op == OP_READ);
                cpu_req.write   = (row.op == OP_WRITE);
                cpu_req.byte_en = row.be;
                #1;
                check_flag("stall", stall, exp_miss);
                wait_idle();
                check_bursts(exp_miss && g_dirty, g_tag, exp_miss, tag);
                if (exp_miss) begin
                    g_valid = 1'b1;
                    g_tag   = tag;
                    g_dirty = 1'b0;
                end
                if (row.op == OP_READ) begin
                    check_word("read_data", read_data, golden[idx]);
                end else begin
                    // Byte merge into the CPU view
                    for (int k = 0; k < `BYTES_W; k++) begin
                        if (row.be[k]) golden[idx][8*k +: 8] = row.data[8*k +: 8];
                    end
                    g_dirty = g_dirty | (|row.be);
                end
                @(posedge aclk);
                #5;
            end
        end
        cpu_req = '0;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/cache_types_pkg.sv
design/axi_burst_pkg.sv
design/cache_block_store.sv
design/cache_controller.sv
design/data_cache_top.sv
testbench/axi_mem_model.sv
testbench/tb_data_cache.sv
